/* test/decodeStimulus.txt */
# instr reg2Loc uncond branch memRead memToReg memWrite aluSrc regWrite aluOp extend shift sh simd
# All fields hex; simd=1 means a zero word, otherwise immediates are slices of instr
14000010 0 1 0 0 0 0 0 0 00 0 0 0 0  # B
94000020 0 1 0 0 0 0 0 1 00 0 0 0 0  # BL
54000040 0 0 1 0 0 0 0 0 00 0 0 0 0  # B.cond
D61F0020 0 0 1 0 0 0 0 0 12 0 0 0 0  # BR X1
D63F0040 0 0 1 0 0 0 0 1 12 0 0 0 0  # BLR X2
B4000063 0 0 1 0 0 0 0 0 07 0 0 0 0  # CBZ X3
F9400441 0 0 0 1 1 0 1 1 00 3 0 0 0  # LDR X1, imm
B9400441 0 0 0 1 1 0 1 1 00 2 0 0 0  # LDR W1, imm
79400441 0 0 0 1 1 0 1 1 00 1 0 0 0  # LDRH, imm
39400441 0 0 0 1 1 0 1 1 00 0 0 0 0  # LDRB, imm
F9000441 1 0 0 0 0 1 1 0 00 3 0 0 0  # STR X1, imm
39000441 1 0 0 0 0 1 1 0 00 0 0 0 0  # STRB, imm
B9800441 0 0 0 1 1 0 1 1 00 6 0 0 0  # LDRSW, imm
F8236841 1 0 0 0 0 1 0 0 00 0 0 0 0  # STR X1, reg
B14004C5 0 0 0 0 0 0 1 1 01 8 0 1 0  # ADDS imm, LSL 12
F1000C5F 0 0 0 0 0 0 1 0 07 8 0 0 0  # CMP imm
B1000C5F 0 0 0 0 0 0 1 0 10 8 0 0 0  # CMN imm
92401C20 0 0 0 0 0 0 1 1 09 A 0 0 0  # AND imm
D2A24680 0 0 0 0 0 0 1 1 12 8 1 0 0  # MOVZ, hw 1
92800000 0 0 0 0 0 0 1 1 13 8 0 0 0  # MOVN
EB450883 0 0 0 0 0 0 0 1 03 3 1 0 0  # SUBS reg, LSR
EB05009F 0 0 0 0 0 0 0 0 07 3 0 0 0  # CMP reg
AA820C20 0 0 0 0 0 0 0 1 0A 0 2 0 0  # ORR reg, ASR
1E622820 0 0 0 0 0 0 0 0 00 0 0 0 1  # FADD, SIMD class

/* controlUnit.f */
verilog/decodePkg.sv
verilog/instrClassifier.sv
verilog/branchDecoder.sv
verilog/memDecoder.sv
verilog/aluDecoder.sv
verilog/ctrlRegister.sv
verilog/controlUnit.sv
test/controlUnitTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = controlUnitTb
FILELIST  = controlUnit.f
PASS_MSG  = All tests passed

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* test/controlUnitTb.sv */
`timescale 1ns/1ns

module controlUnitTb import decodePkg::*; ();

    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        logic               reg2Loc;
        logic               uncond;
        logic               branch;
        logic               memRead;
        logic               memToReg;
        logic               memWrite;
        logic               aluSrc;
        logic               regWrite;
        aluOpT              aluOp;
        extendModeT         ext;
        shiftModeT          shift;
        logic               sh;
        logic               simd;                   // Whole word expected zero
    } vecT;

    logic               clk;
    logic               rst;
    logic [INSTR_W-1:0] instr;
    logic               instrValid, instrReady, ctrlValid, ctrlReady;
    logic               reg2Loc, uncondBranch, branch, memRead;
    logic               memToReg, memWrite, aluSrc, regWrite, sh;
    aluOpT              aluOp;
    extendModeT         extendMode;
    shiftModeT          shiftMode;
    logic [IMM3_W-1:0]  imm3;
    logic [IMM6_W-1:0]  imm6;
    logic [IMM12_W-1:0] imm12;
    logic [IMMSR_W-1:0] immS, immR;

    vecT vecs[$];                                   // As read from file
    vecT expQ[$];                                   // Accepted, not yet delivered
    int  cycles = 0;
    int  cycleLimit = 0;
    int  transfers = 0;
    bit  streaming, randomReady;
    bit  latencyChecked = 1'b0;

    controlUnit u_controlUnit (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Failure and compare tasks
    // ------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkFlag(input string test, input string field, input logic exp,
                             input logic act);
        if (act !== exp) begin
            failRun($sformatf("FAIL %s %s: expected %0b, actual %0b", test, field, exp, act));
        end
    endtask

    task automatic checkAluOp(input string test, input aluOpT exp, input aluOpT act);
        if (act !== exp) begin
            failRun($sformatf("FAIL %s aluOp: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic checkExtend(input string test, input extendModeT exp, input extendModeT act);
        if (act !== exp) begin
            failRun($sformatf("FAIL %s extendMode: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic checkShift(input string test, input shiftModeT exp, input shiftModeT act);
        if (act !== exp) begin
            failRun($sformatf("FAIL %s shiftMode: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic checkImm(input string test, input string field, input logic [11:0] exp,
                            input logic [11:0] act);
        if (act !== exp) begin
            failRun($sformatf("FAIL %s %s: expected %0h, actual %0h", test, field, exp, act));
        end
    endtask

    // Whole control word against one vector, immediates sliced here from instr
    task automatic checkWord(input string test, input vecT v);
        logic [11:0] ex3, ex6, ex12, exS, exR;
        ex3  = v.simd ? 12'd0 : {9'd0, v.instr[18:16]};
        ex6  = v.simd ? 12'd0 : {6'd0, v.instr[21:16]};
        ex12 = v.simd ? 12'd0 : v.instr[21:10];
        exS  = v.simd ? 12'd0 : {6'd0, v.instr[15:10]};
        exR  = ex6;                                 // Same field as imm6
        checkFlag(test, "reg2Loc", v.reg2Loc, reg2Loc);
        checkFlag(test, "uncondBranch", v.uncond, uncondBranch);
        checkFlag(test, "branch", v.branch, branch);
        checkFlag(test, "memRead", v.memRead, memRead);
        checkFlag(test, "memToReg", v.memToReg, memToReg);
        checkFlag(test, "memWrite", v.memWrite, memWrite);
        checkFlag(test, "aluSrc", v.aluSrc, aluSrc);
        checkFlag(test, "regWrite", v.regWrite, regWrite);
        checkFlag(test, "sh", v.sh, sh);
        checkAluOp(test, v.aluOp, aluOp);
        checkExtend(test, v.ext, extendMode);
        checkShift(test, v.shift, shiftMode);
        checkImm(test, "imm3", ex3, {9'd0, imm3});
        checkImm(test, "imm6", ex6, {6'd0, imm6});
        checkImm(test, "imm12", ex12, imm12);
        checkImm(test, "immS", exS, {5'd0, immS});
        checkImm(test, "immR", exR, {5'd0, immR});
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic readVectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [14];
        vecT         v;
        fd = $fopen("test/decodeStimulus.txt", "r");
        if (fd == 0) begin
            failRun("Cannot open test/decodeStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin   // Skip header and blanks
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                  f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                    if (cnt != 14) begin
                        failRun($sformatf("Malformed stimulus line: %s", line));
                    end else begin
                        v.instr    = f[0];
                        v.reg2Loc  = f[1][0];
                        v.uncond   = f[2][0];
                        v.branch   = f[3][0];
                        v.memRead  = f[4][0];
                        v.memToReg = f[5][0];
                        v.memWrite = f[6][0];
                        v.aluSrc   = f[7][0];
                        v.regWrite = f[8][0];
                        v.aluOp    = aluOpT'(f[9][4:0]);
                        v.ext      = extendModeT'(f[10][3:0]);
                        v.shift    = f[11][1:0];
                        v.sh       = f[12][0];
                        v.simd     = f[13][0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // All vectors once, instrValid held until each is taken
    task automatic sendAll(input bit gaps);
        int i;
        i = 0;
        while (i < vecs.size()) begin
            if (gaps && ($urandom_range(3) == 0)) begin
                instrValid <= 1'b0;                 // Idle cycle
                @(posedge clk);
            end else begin
                instrValid <= 1'b1;
                instr      <= vecs[i].instr;
                do begin
                    @(posedge clk);
                end while (!instrReady);
                expQ.push_back(vecs[i]);
                i++;
            end
        end
        instrValid <= 1'b0;
    endtask

    task automatic checkReset();
        vecT zero;
        zero      = '0;
        zero.simd = 1'b1;                           // Immediates cleared too
        checkWord("after reset", zero);
        checkFlag("after reset", "ctrlValid", 1'b0, ctrlValid);
        checkFlag("after reset", "instrReady", 1'b1, instrReady);
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > cycleLimit) begin
                failRun("Timeout: outputs stopped arriving");
            end else begin
                if (transfers == 1 && !latencyChecked) begin
                    checkFlag("first transfer", "ctrlValid", 1'b1, ctrlValid);  // One cycle on
                    latencyChecked = 1'b1;
                end
                if (streaming && instrValid) begin
                    checkFlag("streaming", "instrReady", 1'b1, instrReady);
                end
                if (ctrlValid && expQ.size() == 0) begin
                    failRun("Output word arrived with no instruction pending");
                end else if (ctrlValid) begin
                    checkWord($sformatf("vector %08h", expQ[0].instr), expQ[0]);  // Also while held
                    if (ctrlReady) begin
                        void'(expQ.pop_front());
                    end
                end
                if (instrValid && instrReady) begin
                    transfers++;
                end
            end
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'h857bc783));
        rst         <= 1'b1;
        instr       <= '0;
        instrValid  <= 1'b0;
        ctrlReady   <= 1'b1;
        streaming   <= 1'b1;
        randomReady <= 1'b0;
        readVectors();
        cycleLimit = vecs.size() * 8 + 50;
        fork
            forever begin
                @(posedge clk);
                if (randomReady) begin
                    ctrlReady <= ($urandom_range(2) != 0);  // Ready two cycles in three
                end else begin
                    ctrlReady <= 1'b1;
                end
            end
        join_none
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkReset();
        sendAll(1'b0);                              // Back to back, no back-pressure
        while (expQ.size() != 0) @(posedge clk);
        streaming   <= 1'b0;
        randomReady <= 1'b1;
        sendAll(1'b1);
        while (expQ.size() != 0) @(posedge clk);
        @(posedge clk);                             // Slot empties after the last take
        if (!ctrlValid) begin
            $display("All tests passed");
            $finish;
        end else begin
            failRun("Output still valid after the last word was taken");
        end
    end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ns

module controlUnit import decodePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [INSTR_W-1:0] instr,
    input  logic               instrValid,
    output logic               instrReady,
    output logic               ctrlValid,
    input  logic               ctrlReady,
    output logic               reg2Loc,
    output logic               uncondBranch,
    output logic               branch,
    output logic               memRead,
    output logic               memToReg,
    output logic               memWrite,
    output logic               aluSrc,
    output logic               regWrite,
    output aluOpT              aluOp,
    output extendModeT         extendMode,
    output shiftModeT          shiftMode,
    output logic               sh,
    output logic [IMM3_W-1:0]  imm3,
    output logic [IMM6_W-1:0]  imm6,
    output logic [IMM12_W-1:0] imm12,
    output logic [IMMSR_W-1:0] immS,
    output logic [IMMSR_W-1:0] immR
);

    // ------------------------------
    // Decoder group wires
    // ------------------------------
    instrClassT instrClass;
    logic       brUncond, brCond, brRegWrite, brAluSrc;
    aluOpT      brAluOp;
    logic       memRd, memLoadWb, memWr, memReg2Loc, memRegWrite, memAluSrc;
    extendModeT memExtend;
    aluOpT      aluOpOut;
    logic       aluSrcOut, aluRegWrite, aluSh;
    extendModeT aluExtend;
    shiftModeT  aluShift;

    instrClassifier u_instrClassifier (.*);    // Picks the group
    branchDecoder   u_branchDecoder   (.*);
    memDecoder      u_memDecoder      (.memToReg(memLoadWb), .*);  // Avoids word name
    aluDecoder      u_aluDecoder      (.*);    // Both data-processing tables
    ctrlRegister    u_ctrlRegister    (.*);    // One-cycle output stage

endmodule

/* verilog/ctrlRegister.sv */
`timescale 1ns/1ns

module ctrlRegister import decodePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [INSTR_W-1:0] instr,
    input  logic               instrValid,
    output logic               instrReady,
    input  instrClassT         instrClass,
    input  logic               brUncond, brCond, brRegWrite, brAluSrc,
    input  aluOpT              brAluOp,
    input  logic               memRd, memLoadWb, memWr, memReg2Loc,
    input  logic               memRegWrite, memAluSrc,
    input  extendModeT         memExtend,
    input  aluOpT              aluOpOut,
    input  logic               aluSrcOut, aluRegWrite, aluSh,
    input  extendModeT         aluExtend,
    input  shiftModeT          aluShift,
    output logic               reg2Loc, uncondBranch, branch, memRead,
    output logic               memToReg, memWrite, aluSrc, regWrite,
    output aluOpT              aluOp,
    output extendModeT         extendMode,
    output shiftModeT          shiftMode,
    output logic               sh,
    output logic [IMM3_W-1:0]  imm3,
    output logic [IMM6_W-1:0]  imm6,
    output logic [IMM12_W-1:0] imm12,
    output logic [IMMSR_W-1:0] immS,
    output logic [IMMSR_W-1:0] immR,
    output logic               ctrlValid,
    input  logic               ctrlReady
);

    logic load;                                 // Input transfer this cycle

    assign instrReady = !ctrlValid || ctrlReady;  // Slot empty or leaving
    assign load       = instrValid && instrReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrlValid <= 1'b0;
        end else if (load) begin
            ctrlValid <= 1'b1;
        end else if (ctrlReady) begin
            ctrlValid <= 1'b0;                  // Word taken, nothing new
        end
    end

    // ------------------------------
    // Control word register
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {reg2Loc, uncondBranch, branch, memRead, memToReg, memWrite} <= '0;
            {aluSrc, regWrite, shiftMode, sh} <= '0;
            aluOp      <= ALU_ADD;
            extendMode <= EXT_BYTE;
            {imm3, imm6, imm12, immS, immR} <= '0;
        end else if (load) begin
            {reg2Loc, uncondBranch, branch, memRead, memToReg, memWrite} <= '0;
            {aluSrc, regWrite, shiftMode, sh} <= '0;
            aluOp      <= ALU_ADD;              // Also the address add for loads/stores
            extendMode <= EXT_BYTE;
            imm3       <= instr[18:16];
            imm6       <= instr[21:16];
            imm12      <= instr[21:10];
            immS       <= IMMSR_W'(instr[15:10]);  // Zero-extended
            immR       <= IMMSR_W'(instr[21:16]);
            case (instrClass)
                CLS_BRANCH: begin
                    uncondBranch <= brUncond;
                    branch       <= brCond;
                    aluSrc       <= brAluSrc;
                    regWrite     <= brRegWrite;
                    aluOp        <= brAluOp;
                end
                CLS_LDST: begin
                    reg2Loc    <= memReg2Loc;
                    memRead    <= memRd;
                    memToReg   <= memLoadWb;
                    memWrite   <= memWr;
                    aluSrc     <= memAluSrc;
                    regWrite   <= memRegWrite;
                    extendMode <= memExtend;
                end
                CLS_DP_IMM, CLS_DP_REG: begin
                    aluOp      <= aluOpOut;
                    aluSrc     <= aluSrcOut;
                    regWrite   <= aluRegWrite;
                    sh         <= aluSh;
                    extendMode <= aluExtend;
                    shiftMode  <= aluShift;
                end
                default: begin
                    {imm3, imm6, imm12, immS, immR} <= '0;  // SIMD/FP, empty word
                end
            endcase
        end
    end

endmodule

/* verilog/aluDecoder.sv */
`timescale 1ns/1ns

module aluDecoder import decodePkg::*; (
    input  logic [INSTR_W-1:0] instr,
    output aluOpT              aluOpOut,
    output logic               aluSrcOut,
    output logic               aluRegWrite,
    output logic               aluSh,
    output extendModeT         aluExtend,
    output shiftModeT          aluShift
);

    logic [8:0]  immOp;                         // Immediate table key [31:23]
    logic [10:0] regOp;                         // Register table key [31:21]
    logic        rdZero;
    logic        flagOnly;                      // CMP/CMN, result dropped
    logic        immAddSub, immLogic, immMove;
    logic        regAddSub, regLogic;
    aluOpT       addSubOp, logicOp;

    assign immOp    = instr[31:23];
    assign regOp    = instr[31:21] & DP_REG_MASK;
    assign rdZero   = (instr[4:0] == ZERO_REG);
    assign flagOnly = instr[29] && rdZero;      // S set with XZR destination

    assign immAddSub = immOp inside {OP_ADD_IMM, OP_ADDS_IMM, OP_SUB_IMM, OP_SUBS_IMM};
    assign immLogic  = immOp inside {OP_AND_IMM, OP_ORR_IMM, OP_EOR_IMM, OP_ANDS_IMM};
    assign immMove   = immOp inside {OP_MOVZ_IMM, OP_MOVN_IMM};
    assign regAddSub = regOp inside {OP_ADD_REG, OP_ADDS_REG, OP_SUB_REG, OP_SUBS_REG};
    assign regLogic  = regOp inside {OP_AND_REG, OP_ORR_REG, OP_EOR_REG, OP_ANDS_REG};

    // ------------------------------
    // Opcode from op/S bits [30:29]
    // ------------------------------
    always_comb begin
        if (flagOnly) begin
            addSubOp = instr[30] ? ALU_CMP : ALU_CMN;  // Checked ahead of SUBS/ADDS
        end else begin
            case (instr[30:29])
                2'b00:   addSubOp = ALU_ADD;
                2'b01:   addSubOp = ALU_ADDS;
                2'b10:   addSubOp = ALU_SUB;
                default: addSubOp = ALU_SUBS;
            endcase
        end
        case (instr[30:29])                     // Same opc field in both tables
            2'b00:   logicOp = ALU_AND;
            2'b01:   logicOp = ALU_ORR;
            2'b10:   logicOp = ALU_EOR;
            default: logicOp = ALU_ANDS;
        endcase
    end

    always_comb begin
        aluOpOut    = ALU_ADD;
        aluSrcOut   = 1'b0;
        aluRegWrite = 1'b0;
        aluSh       = 1'b0;
        aluExtend   = EXT_BYTE;
        aluShift    = '0;
        if (immAddSub) begin
            aluOpOut    = addSubOp;
            aluSrcOut   = 1'b1;
            aluRegWrite = !flagOnly;
            aluSh       = instr[22];            // imm12 LSL 12
            aluExtend   = EXT_IMM;
        end else if (immLogic) begin
            aluOpOut    = logicOp;
            aluSrcOut   = 1'b1;
            aluRegWrite = 1'b1;
            aluExtend   = EXT_LOGIMM;           // N:immr:imms bitmask
        end else if (immMove) begin
            aluOpOut    = (immOp == OP_MOVZ_IMM) ? ALU_MOV : ALU_MVN;
            aluSrcOut   = 1'b1;
            aluRegWrite = 1'b1;
            aluExtend   = EXT_IMM;
            aluShift    = instr[22:21];         // hw, 16-bit steps
        end else if (regAddSub) begin
            aluOpOut    = addSubOp;
            aluRegWrite = !flagOnly;
            aluExtend   = EXT_DOUBLE;           // Full 64-bit operand
            aluShift    = instr[23:22];
        end else if (regLogic) begin
            aluOpOut    = logicOp;
            aluRegWrite = 1'b1;
            aluShift    = instr[23:22];
        end
    end

endmodule

/* verilog/memDecoder.sv */
`timescale 1ns/1ns

module memDecoder import decodePkg::*; (
    input  logic [INSTR_W-1:0] instr,
    output logic               memRd,
    output logic               memToReg,
    output logic               memWr,
    output logic               memReg2Loc,
    output logic               memRegWrite,
    output logic               memAluSrc,
    output extendModeT         memExtend
);

    logic ldImm, stImm, ldReg, stReg;           // Size-agnostic forms
    logic ldswImm, ldswReg;                     // Signed word loads
    logic isLoad, isStore;

    // Size bits [31:30] left out so one prefix covers byte to doubleword
    assign ldImm   = (instr[29:22] == OP_LDR_IMM);
    assign stImm   = (instr[29:22] == OP_STR_IMM);
    assign ldReg   = (instr[29:21] == OP_LDR_REG);
    assign stReg   = (instr[29:21] == OP_STR_REG);
    assign ldswImm = (instr[31:22] == OP_LDRSW_IMM);
    assign ldswReg = (instr[31:21] == OP_LDRSW_REG);

    assign isLoad  = ldImm || ldReg || ldswImm || ldswReg;
    assign isStore = stImm || stReg;

    assign memRd       = isLoad;
    assign memToReg    = isLoad;                // Write-back from memory
    assign memRegWrite = isLoad;
    assign memWr       = isStore;
    assign memReg2Loc  = isStore;               // Rt read as store data
    assign memAluSrc   = ldImm || stImm || ldswImm;  // Scaled imm12 offset

    // ------------------------------
    // Access size
    // ------------------------------
    always_comb begin
        if (ldswImm || ldswReg) begin
            memExtend = EXT_SWORD;
        end else if (ldImm || stImm) begin
            memExtend = extendModeT'({2'b00, instr[31:30]});  // Size field as is
        end else begin
            memExtend = EXT_BYTE;               // Register forms, no scaling
        end
    end

endmodule

/* verilog/branchDecoder.sv */
`timescale 1ns/1ns

module branchDecoder import decodePkg::*; (
    input  logic [INSTR_W-1:0] instr,
    output logic               brUncond,
    output logic               brCond,
    output logic               brRegWrite,
    output logic               brAluSrc,
    output aluOpT              brAluOp
);

    always_comb begin
        brUncond   = 1'b0;
        brCond     = 1'b0;
        brRegWrite = 1'b0;
        brAluSrc   = 1'b0;                      // Branch operands are registers
        brAluOp    = ALU_ADD;
        if (instr[31:26] == OP_B) begin
            brUncond = 1'b1;                    // PC-relative, imm26
        end else if (instr[31:26] == OP_BL) begin
            brUncond   = 1'b1;
            brRegWrite = 1'b1;                  // Link into X30
        end else if (instr[31:24] == OP_BCOND) begin
            brCond = 1'b1;                      // Flags tested downstream
        end else if (instr[31:10] == OP_BR) begin
            brCond  = 1'b1;
            brAluOp = ALU_MOV;                  // Rn passed as target
        end else if (instr[31:10] == OP_BLR) begin
            brCond     = 1'b1;
            brRegWrite = 1'b1;
            brAluOp    = ALU_MOV;
        end else if (instr[31:24] == OP_CBZ) begin
            brCond  = 1'b1;
            brAluOp = ALU_CMP;                  // Compare Rt against zero
        end
    end

endmodule

/* verilog/instrClassifier.sv */
`timescale 1ns/1ns

module instrClassifier import decodePkg::*; (
    input  logic [INSTR_W-1:0] instr,
    output instrClassT         instrClass
);

    logic [3:0] majorOp;                        // Top-level op0 group
    logic       sfBit;                          // Operand size, 64-bit when set

    assign majorOp = instr[28:25];
    assign sfBit   = instr[31];

    // ------------------------------
    // Major group sort
    // ------------------------------
    always_comb begin
        casez (majorOp)
            4'b100?: instrClass = CLS_DP_IMM;   // Add/sub, logical, move wide
            4'b101?: instrClass = CLS_BRANCH;   // Branch, CBZ, system space
            4'b?1?0: instrClass = CLS_LDST;     // All load/store forms
            4'b?101: instrClass = CLS_DP_REG;   // Shifted and extended register
            4'b?111: instrClass = CLS_SIMD;     // Scalar FP and SIMD
            default: begin
                // Unallocated space, size bit picks a data-processing group
                if (sfBit) begin
                    instrClass = CLS_DP_REG;
                end else begin
                    instrClass = CLS_DP_IMM;
                end
            end
        endcase
    end

endmodule

/* verilog/decodePkg.sv */
package decodePkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    localparam int INSTR_W = 32;             // Fixed A64 instruction word
    localparam int IMM3_W  = 3;
    localparam int IMM6_W  = 6;
    localparam int IMM12_W = 12;
    localparam int IMMSR_W = 7;              // Bitmask fields, zero-extended

    localparam logic [4:0] ZERO_REG = 5'd31; // XZR as destination

    // ------------------------------
    // Enumerations
    // ------------------------------
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_ADDS = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_SUBS = 5'd3,
        ALU_CMP  = 5'd7,
        ALU_AND  = 5'd9,
        ALU_ORR  = 5'd10,
        ALU_EOR  = 5'd11,
        ALU_CMN  = 5'd16,
        ALU_ANDS = 5'd17,
        ALU_MOV  = 5'd18,                    // Pass operand through
        ALU_MVN  = 5'd19
    } aluOpT;

    typedef enum logic [2:0] {
        CLS_DP_IMM,
        CLS_DP_REG,
        CLS_BRANCH,
        CLS_LDST,
        CLS_SIMD                             // Recognised only, no control
    } instrClassT;

    typedef enum logic [3:0] {
        EXT_BYTE   = 4'd0,                   // Equal to size field [31:30]
        EXT_HALF   = 4'd1,
        EXT_WORD   = 4'd2,
        EXT_DOUBLE = 4'd3,
        EXT_SWORD  = 4'd6,                   // Sign-extended word load
        EXT_IMM    = 4'd8,                   // Plain 12/16-bit immediate
        EXT_LOGIMM = 4'd10                   // Bitmask immediate
    } extendModeT;

    typedef logic [1:0] shiftModeT;          // Shift type or hw count

    // ------------------------------
    // Encoding prefixes
    // ------------------------------
    localparam logic [5:0]  OP_B     = 6'b000101;                  // [31:26]
    localparam logic [5:0]  OP_BL    = 6'b100101;                  // [31:26]
    localparam logic [7:0]  OP_BCOND = 8'b01010100;                // [31:24]
    localparam logic [21:0] OP_BR    = 22'b1101011000011111000000; // [31:10]
    localparam logic [21:0] OP_BLR   = 22'b1101011000111111000000; // [31:10]
    localparam logic [7:0]  OP_CBZ   = 8'b10110100;                // [31:24], 64-bit

    localparam logic [7:0]  OP_LDR_IMM   = 8'b11100101;            // [29:22], any size
    localparam logic [7:0]  OP_STR_IMM   = 8'b11100100;            // [29:22]
    localparam logic [8:0]  OP_LDR_REG   = 9'b111000011;           // [29:21]
    localparam logic [8:0]  OP_STR_REG   = 9'b111000001;           // [29:21]
    localparam logic [9:0]  OP_LDRSW_IMM = 10'b1011100110;         // [31:22]
    localparam logic [10:0] OP_LDRSW_REG = 11'b10111000101;        // [31:21]

    localparam logic [8:0]  OP_ADD_IMM  = 9'b100100010;            // [31:23]
    localparam logic [8:0]  OP_ADDS_IMM = 9'b101100010;
    localparam logic [8:0]  OP_SUB_IMM  = 9'b110100010;
    localparam logic [8:0]  OP_SUBS_IMM = 9'b111100010;
    localparam logic [8:0]  OP_AND_IMM  = 9'b100100100;
    localparam logic [8:0]  OP_ORR_IMM  = 9'b101100100;
    localparam logic [8:0]  OP_EOR_IMM  = 9'b110100100;
    localparam logic [8:0]  OP_ANDS_IMM = 9'b111100100;
    localparam logic [8:0]  OP_MOVN_IMM = 9'b100100101;
    localparam logic [8:0]  OP_MOVZ_IMM = 9'b110100101;

    localparam logic [10:0] DP_REG_MASK = 11'b11111111001;         // Drops shift [23:22]
    localparam logic [10:0] OP_ADD_REG  = 11'b10001011000;         // [31:21], shifted reg
    localparam logic [10:0] OP_ADDS_REG = 11'b10101011000;
    localparam logic [10:0] OP_SUB_REG  = 11'b11001011000;
    localparam logic [10:0] OP_SUBS_REG = 11'b11101011000;
    localparam logic [10:0] OP_AND_REG  = 11'b10001010000;
    localparam logic [10:0] OP_ORR_REG  = 11'b10101010000;
    localparam logic [10:0] OP_EOR_REG  = 11'b11001010000;
    localparam logic [10:0] OP_ANDS_REG = 11'b11101010000;

endpackage
